/* logic/prf_cfg.svh */
/*
    Register file sizing constants
    shared by the package and every RTL block
*/

`ifndef PRF_CFG_SVH
`define PRF_CFG_SVH

// storage geometry
`define PRF_PR_COUNT    32
`define PRF_BANK_COUNT  4
`define PRF_DATA_WIDTH  32

// requestors and their input buffering
`define PRF_RR_COUNT    4
`define PRF_WR_COUNT    2
`define PRF_BUF_DEPTH   2

`endif

/* logic/prf_pkg.sv */
/*
    Register file types
    vector typedefs for PR numbers, bank selects and requestor masks
*/

`include "prf_cfg.svh"

package prf_pkg;

    // PR number split into bank bits and in-bank index
    typedef logic [$clog2(`PRF_PR_COUNT)-1:0] pr_t;
    typedef logic [$clog2(`PRF_BANK_COUNT)-1:0] bank_t;
    typedef logic [$clog2(`PRF_PR_COUNT)-$clog2(`PRF_BANK_COUNT)-1:0] upper_pr_t;

    typedef logic [`PRF_DATA_WIDTH-1:0] reg_data_t;
    typedef logic [`PRF_BANK_COUNT-1:0] bank_mask_t;

    // one bit per requestor
    typedef logic [`PRF_RR_COUNT-1:0] rr_vec_t;
    typedef logic [`PRF_WR_COUNT-1:0] wr_vec_t;

endpackage

/* logic/req_buffer.sv */
/*
    Request buffer
    small FIFO in front of the bank arbiters, ready comes from the
    fill count alone so upstream never waits on arbitration
*/

`timescale 1ns/1ns
`include "prf_cfg.svh"

module req_buffer #(
    parameter int WIDTH = 8
)(
    input  logic             CLK,
    input  logic             nRST,
    input  logic             enq_valid,
    input  logic [WIDTH-1:0] enq_data,
    output logic             enq_ready,
    output logic             deq_valid,
    output logic [WIDTH-1:0] deq_data,
    input  logic             deq_ready
);

    localparam int DEPTH = `PRF_BUF_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             do_enq;
    logic             do_deq;

    assign enq_ready = (count != CNT_W'(DEPTH));
    assign deq_valid = (count != '0);
    assign deq_data  = mem[rd_ptr];
    assign do_enq    = enq_valid & enq_ready;
    assign do_deq    = deq_valid & deq_ready;

    // pointers wrap at DEPTH
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_enq) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_deq) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_enq && !do_deq) begin
                count <= count + 1'b1;
            end else if (!do_enq && do_deq) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (do_enq) begin
            mem[wr_ptr] <= enq_data;
        end
    end

endmodule

/* logic/rr_arbiter.sv */
/*
    Round-robin arbiter, one grant per cycle
    arbitrates the write requestors of one bank
*/

`timescale 1ns/1ns
`include "prf_cfg.svh"

module rr_arbiter (
    input  logic              CLK,
    input  logic              nRST,
    input  prf_pkg::wr_vec_t  req_vec,
    output prf_pkg::wr_vec_t  grant,
    output logic              grant_valid
);

    import prf_pkg::*;

    localparam int N     = `PRF_WR_COUNT;
    localparam int PTR_W = (N > 1) ? $clog2(N) : 1;

    logic [PTR_W-1:0] ptr;
    logic [PTR_W-1:0] grant_idx;

    // search starts at the priority pointer
    always_comb begin
        int unsigned idx;
        grant       = '0;
        grant_valid = 1'b0;
        grant_idx   = ptr;
        for (int i = 0; i < N; i++) begin
            idx = (int'(ptr) + i) % N;
            if (!grant_valid && req_vec[idx]) begin
                grant[idx]  = 1'b1;
                grant_valid = 1'b1;
                grant_idx   = PTR_W'(idx);
            end
        end
    end

    // winner drops to lowest priority
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            ptr <= '0;
        end else if (grant_valid) begin
            ptr <= PTR_W'((int'(grant_idx) + 1) % N);
        end
    end

endmodule

/* logic/rr_dual_arbiter.sv */
/*
    Round-robin arbiter, two grants per cycle
    feeds the two read ports of one bank, grant0 to the first
    requestor from the pointer and grant1 to the next one after it
*/

`timescale 1ns/1ns
`include "prf_cfg.svh"

module rr_dual_arbiter (
    input  logic              CLK,
    input  logic              nRST,
    input  prf_pkg::rr_vec_t  req_vec,
    output prf_pkg::rr_vec_t  grant0,
    output prf_pkg::rr_vec_t  grant1
);

    import prf_pkg::*;

    localparam int N     = `PRF_RR_COUNT;
    localparam int PTR_W = (N > 1) ? $clog2(N) : 1;

    logic [PTR_W-1:0] ptr;
    logic [PTR_W-1:0] last_idx;
    logic [1:0]       grant_cnt;

    // --------------------------------------------------
    // grant search
    // --------------------------------------------------

    always_comb begin
        int unsigned idx;
        grant0    = '0;
        grant1    = '0;
        grant_cnt = 2'd0;
        last_idx  = ptr;
        for (int i = 0; i < N; i++) begin
            idx = (int'(ptr) + i) % N;
            if (req_vec[idx]) begin
                if (grant_cnt == 2'd0) begin
                    grant0[idx] = 1'b1;
                    grant_cnt   = 2'd1;
                    last_idx    = PTR_W'(idx);
                end else if (grant_cnt == 2'd1) begin
                    grant1[idx] = 1'b1;
                    grant_cnt   = 2'd2;
                    last_idx    = PTR_W'(idx);
                end
            end
        end
    end

    // --------------------------------------------------
    // priority pointer
    // --------------------------------------------------

    // moves past whichever grant came last
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            ptr <= '0;
        end else if (grant_cnt != 2'd0) begin
            ptr <= PTR_W'((int'(last_idx) + 1) % N);
        end
    end

endmodule

/* logic/prf_bank_ram.sv */
/*
    Register file bank
    eight registers, two asynchronous read ports, one clocked write
*/

`timescale 1ns/1ns
`include "prf_cfg.svh"

module prf_bank_ram (
    input  logic                CLK,
    input  prf_pkg::upper_pr_t  rindex0,
    output prf_pkg::reg_data_t  rdata0,
    input  prf_pkg::upper_pr_t  rindex1,
    output prf_pkg::reg_data_t  rdata1,
    input  logic                wen,
    input  prf_pkg::upper_pr_t  windex,
    input  prf_pkg::reg_data_t  wdata
);

    import prf_pkg::*;

    localparam int ENTRIES = `PRF_PR_COUNT / `PRF_BANK_COUNT;

    reg_data_t regs [ENTRIES];

    // reads see the old value during a same-cycle write
    assign rdata0 = regs[rindex0];
    assign rdata1 = regs[rindex1];

    always_ff @(posedge CLK) begin
        if (wen) begin
            regs[windex] <= wdata;
        end
    end

endmodule

/* logic/prf_read_path.sv */
/*
    Register file read path
    buffers read requests, steers each head to its bank, arbitrates
    two reads per bank and returns data to the granted requestors
*/

`timescale 1ns/1ns
`include "prf_cfg.svh"

module prf_read_path (
    input  logic                                          CLK,
    input  logic                                          nRST,
    input  prf_pkg::rr_vec_t                              read_req_valid,
    input  prf_pkg::pr_t [`PRF_RR_COUNT-1:0]              read_req_pr,
    output prf_pkg::rr_vec_t                              read_req_ready,
    output prf_pkg::rr_vec_t                              read_resp_valid,
    output prf_pkg::reg_data_t [`PRF_RR_COUNT-1:0]        read_resp_data,
    output prf_pkg::upper_pr_t [`PRF_BANK_COUNT-1:0]      port0_index,
    output prf_pkg::upper_pr_t [`PRF_BANK_COUNT-1:0]      port1_index,
    input  prf_pkg::reg_data_t [`PRF_BANK_COUNT-1:0]      port0_data,
    input  prf_pkg::reg_data_t [`PRF_BANK_COUNT-1:0]      port1_data
);

    import prf_pkg::*;

    localparam int RR      = `PRF_RR_COUNT;
    localparam int BANKS   = `PRF_BANK_COUNT;
    localparam int BANK_W  = $bits(bank_t);
    localparam int UPPER_W = $bits(upper_pr_t);
    localparam int ENTRY_W = UPPER_W + BANKS;

    bank_t      [RR-1:0]              req_bank;
    logic       [RR-1:0][ENTRY_W-1:0] enq_entry;
    logic       [RR-1:0][ENTRY_W-1:0] deq_entry;
    rr_vec_t                          deq_valid;
    rr_vec_t                          granted;
    rr_vec_t    [BANKS-1:0]           arb_req;
    rr_vec_t    [BANKS-1:0]           grant0;
    rr_vec_t    [BANKS-1:0]           grant1;

    // entry is {upper PR, bank mask}
    always_comb begin
        for (int rr = 0; rr < RR; rr++) begin
            req_bank[rr] = read_req_pr[rr][BANK_W-1:0];
            enq_entry[rr] = '0;
            enq_entry[rr][ENTRY_W-1 -: UPPER_W] = read_req_pr[rr][$bits(pr_t)-1:BANK_W];
            enq_entry[rr][req_bank[rr]] = 1'b1;
        end
    end

    for (genvar rr = 0; rr < RR; rr++) begin : g_read_buf
        req_buffer #(
            .WIDTH(ENTRY_W)
        ) read_buf (
            .CLK       (CLK),
            .nRST      (nRST),
            .enq_valid (read_req_valid[rr]),
            .enq_data  (enq_entry[rr]),
            .enq_ready (read_req_ready[rr]),
            .deq_valid (deq_valid[rr]),
            .deq_data  (deq_entry[rr]),
            .deq_ready (granted[rr])
        );
    end

    // --------------------------------------------------
    // per-bank arbitration and port index select
    // --------------------------------------------------

    for (genvar b = 0; b < BANKS; b++) begin : g_read_arb
        for (genvar rr = 0; rr < RR; rr++) begin : g_steer
            assign arb_req[b][rr] = deq_valid[rr] & deq_entry[rr][b];
        end

        rr_dual_arbiter read_arb (
            .CLK     (CLK),
            .nRST    (nRST),
            .req_vec (arb_req[b]),
            .grant0  (grant0[b]),
            .grant1  (grant1[b])
        );
    end

    // one-hot grants, so OR-select is enough
    always_comb begin
        port0_index    = '0;
        port1_index    = '0;
        granted        = '0;
        read_resp_data = '0;
        for (int b = 0; b < BANKS; b++) begin
            for (int rr = 0; rr < RR; rr++) begin
                if (grant0[b][rr]) begin
                    port0_index[b]     |= deq_entry[rr][ENTRY_W-1 -: UPPER_W];
                    read_resp_data[rr] |= port0_data[b];
                end
                if (grant1[b][rr]) begin
                    port1_index[b]     |= deq_entry[rr][ENTRY_W-1 -: UPPER_W];
                    read_resp_data[rr] |= port1_data[b];
                end
                granted[rr] |= grant0[b][rr] | grant1[b][rr];
            end
        end
    end

    assign read_resp_valid = granted;

endmodule

/* logic/prf_write_path.sv */
/*
    Register file write path
    buffers writebacks, picks one writer per bank each cycle, drives
    the bank write port and writeback bus, registers forward data
*/

`timescale 1ns/1ns
`include "prf_cfg.svh"

module prf_write_path (
    input  logic                                          CLK,
    input  logic                                          nRST,
    input  prf_pkg::wr_vec_t                              wb_valid,
    input  prf_pkg::pr_t [`PRF_WR_COUNT-1:0]              wb_pr,
    input  prf_pkg::reg_data_t [`PRF_WR_COUNT-1:0]        wb_data,
    output prf_pkg::wr_vec_t                              wb_ready,
    output prf_pkg::bank_mask_t                           wb_bus_valid,
    output prf_pkg::upper_pr_t [`PRF_BANK_COUNT-1:0]      wb_bus_upper_pr,
    output prf_pkg::reg_data_t [`PRF_BANK_COUNT-1:0]      forward_data,
    output prf_pkg::bank_mask_t                           write_en,
    output prf_pkg::upper_pr_t [`PRF_BANK_COUNT-1:0]      write_index,
    output prf_pkg::reg_data_t [`PRF_BANK_COUNT-1:0]      write_data
);

    import prf_pkg::*;

    localparam int WR      = `PRF_WR_COUNT;
    localparam int BANKS   = `PRF_BANK_COUNT;
    localparam int BANK_W  = $bits(bank_t);
    localparam int UPPER_W = $bits(upper_pr_t);
    localparam int DATA_W  = $bits(reg_data_t);
    localparam int ENTRY_W = UPPER_W + BANKS + DATA_W;

    bank_t   [WR-1:0]              wb_bank;
    logic    [WR-1:0][ENTRY_W-1:0] enq_entry;
    logic    [WR-1:0][ENTRY_W-1:0] deq_entry;
    wr_vec_t                       deq_valid;
    wr_vec_t                       deq_ready;
    wr_vec_t [BANKS-1:0]           arb_req;
    wr_vec_t [BANKS-1:0]           arb_grant;

    // entry is {upper PR, bank mask, data}
    always_comb begin
        for (int wr = 0; wr < WR; wr++) begin
            wb_bank[wr] = wb_pr[wr][BANK_W-1:0];
            enq_entry[wr] = '0;
            enq_entry[wr][ENTRY_W-1 -: UPPER_W] = wb_pr[wr][$bits(pr_t)-1:BANK_W];
            enq_entry[wr][DATA_W + int'(wb_bank[wr])] = 1'b1;
            enq_entry[wr][DATA_W-1:0] = wb_data[wr];
        end
    end

    for (genvar wr = 0; wr < WR; wr++) begin : g_wb_buf
        req_buffer #(
            .WIDTH(ENTRY_W)
        ) wb_buf (
            .CLK       (CLK),
            .nRST      (nRST),
            .enq_valid (wb_valid[wr]),
            .enq_data  (enq_entry[wr]),
            .enq_ready (wb_ready[wr]),
            .deq_valid (deq_valid[wr]),
            .deq_data  (deq_entry[wr]),
            .deq_ready (deq_ready[wr])
        );
    end

    // --------------------------------------------------
    // one writer per bank
    // --------------------------------------------------

    for (genvar b = 0; b < BANKS; b++) begin : g_write_arb
        for (genvar wr = 0; wr < WR; wr++) begin : g_steer
            assign arb_req[b][wr] = deq_valid[wr] & deq_entry[wr][DATA_W + b];
        end

        rr_arbiter write_arb (
            .CLK         (CLK),
            .nRST        (nRST),
            .req_vec     (arb_req[b]),
            .grant       (arb_grant[b]),
            .grant_valid (write_en[b])
        );
    end

    always_comb begin
        write_index = '0;
        write_data  = '0;
        deq_ready   = '0;
        for (int b = 0; b < BANKS; b++) begin
            for (int wr = 0; wr < WR; wr++) begin
                if (arb_grant[b][wr]) begin
                    write_index[b] |= deq_entry[wr][ENTRY_W-1 -: UPPER_W];
                    write_data[b]  |= deq_entry[wr][DATA_W-1:0];
                end
                deq_ready[wr] |= arb_grant[b][wr];
            end
        end
    end

    // bus is combinational with the RAM write
    assign wb_bus_valid    = write_en;
    assign wb_bus_upper_pr = write_index;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            forward_data <= '0;
        end else begin
            forward_data <= write_data;
        end
    end

endmodule

/* logic/prf.sv */
/*
    Banked physical register file
    four read and two write requestors over four banks, each bank
    with two read ports and one write port
*/

`timescale 1ns/1ns
`include "prf_cfg.svh"

module prf (
    input  logic                                          CLK,
    input  logic                                          nRST,
    input  prf_pkg::rr_vec_t                              read_req_valid,
    input  prf_pkg::pr_t [`PRF_RR_COUNT-1:0]              read_req_pr,
    output prf_pkg::rr_vec_t                              read_req_ready,
    output prf_pkg::rr_vec_t                              read_resp_valid,
    output prf_pkg::reg_data_t [`PRF_RR_COUNT-1:0]        read_resp_data,
    input  prf_pkg::wr_vec_t                              wb_valid,
    input  prf_pkg::pr_t [`PRF_WR_COUNT-1:0]              wb_pr,
    input  prf_pkg::reg_data_t [`PRF_WR_COUNT-1:0]        wb_data,
    output prf_pkg::wr_vec_t                              wb_ready,
    output prf_pkg::bank_mask_t                           wb_bus_valid,
    output prf_pkg::upper_pr_t [`PRF_BANK_COUNT-1:0]      wb_bus_upper_pr,
    output prf_pkg::reg_data_t [`PRF_BANK_COUNT-1:0]      forward_data
);

    import prf_pkg::*;

    // bank RAM ports
    upper_pr_t  [`PRF_BANK_COUNT-1:0] port0_index;
    upper_pr_t  [`PRF_BANK_COUNT-1:0] port1_index;
    reg_data_t  [`PRF_BANK_COUNT-1:0] port0_data;
    reg_data_t  [`PRF_BANK_COUNT-1:0] port1_data;
    bank_mask_t                       write_en;
    upper_pr_t  [`PRF_BANK_COUNT-1:0] write_index;
    reg_data_t  [`PRF_BANK_COUNT-1:0] write_data;

    prf_read_path read_path (
        .CLK             (CLK),
        .nRST            (nRST),
        .read_req_valid  (read_req_valid),
        .read_req_pr     (read_req_pr),
        .read_req_ready  (read_req_ready),
        .read_resp_valid (read_resp_valid),
        .read_resp_data  (read_resp_data),
        .port0_index     (port0_index),
        .port1_index     (port1_index),
        .port0_data      (port0_data),
        .port1_data      (port1_data)
    );

    prf_write_path write_path (
        .CLK             (CLK),
        .nRST            (nRST),
        .wb_valid        (wb_valid),
        .wb_pr           (wb_pr),
        .wb_data         (wb_data),
        .wb_ready        (wb_ready),
        .wb_bus_valid    (wb_bus_valid),
        .wb_bus_upper_pr (wb_bus_upper_pr),
        .forward_data    (forward_data),
        .write_en        (write_en),
        .write_index     (write_index),
        .write_data      (write_data)
    );

    for (genvar b = 0; b < `PRF_BANK_COUNT; b++) begin : g_bank
        prf_bank_ram bank_ram (
            .CLK     (CLK),
            .rindex0 (port0_index[b]),
            .rdata0  (port0_data[b]),
            .rindex1 (port1_index[b]),
            .rdata1  (port1_data[b]),
            .wen     (write_en[b]),
            .windex  (write_index[b]),
            .wdata   (write_data[b])
        );
    end

endmodule

/* sim/prf_clk_gen.sv */
/*
    Testbench clock and reset
    4 ns clock, reset held low for three cycles
*/

`timescale 1ns/1ns

module prf_clk_gen (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // release just after an edge, like every other input
    initial begin
        nRST = 1'b0;
        repeat (3) @(posedge CLK);
        #1 nRST = 1'b1;
    end

endmodule

/* sim/prf_tb.sv */
/*
    Register file testbench
    random reads and writebacks from an LFSR, checked against a model
    of the register array and of each requestor's pending requests
*/

`timescale 1ns/1ns
`include "prf_cfg.svh"

module prf_tb;

    import prf_pkg::*;

    localparam int RR          = `PRF_RR_COUNT;
    localparam int WR          = `PRF_WR_COUNT;
    localparam int BANKS       = `PRF_BANK_COUNT;
    localparam int DEPTH       = `PRF_BUF_DEPTH;
    localparam int BANK_W      = $bits(bank_t);
    localparam int SEED        = 32799;
    localparam int TIMEOUT     = 400;
    localparam int INIT_WRITES = `PRF_PR_COUNT / WR;
    localparam int RAND_READS  = 40;
    localparam int RAND_WRITES = 30;
    localparam int HOT_READS   = 12;

    logic                       CLK;
    logic                       nRST;
    rr_vec_t                    read_req_valid;
    pr_t        [RR-1:0]        read_req_pr;
    rr_vec_t                    read_req_ready;
    rr_vec_t                    read_resp_valid;
    reg_data_t  [RR-1:0]        read_resp_data;
    wr_vec_t                    wb_valid;
    pr_t        [WR-1:0]        wb_pr;
    reg_data_t  [WR-1:0]        wb_data;
    wr_vec_t                    wb_ready;
    bank_mask_t                 wb_bus_valid;
    upper_pr_t  [BANKS-1:0]     wb_bus_upper_pr;
    reg_data_t  [BANKS-1:0]     forward_data;

    // reference model
    reg_data_t  model_regs [`PRF_PR_COUNT];
    pr_t        rd_pending [RR][$];
    pr_t        wr_pend_pr [WR][$];
    reg_data_t  wr_pend_data [WR][$];
    int         rd_accepted [RR];
    int         resp_count [RR];
    int         wr_accepted [WR];
    int         wb_bus_count;
    bank_mask_t fwd_due;
    reg_data_t  fwd_data [BANKS];

    logic [31:0] lfsr;
    int          check_count;
    int          error_count;
    bit          timed_out;
    bit          saw_ready_low;

    prf_clk_gen clk_gen (
        .CLK  (CLK),
        .nRST (nRST)
    );

    prf DUT (
        .CLK             (CLK),
        .nRST            (nRST),
        .read_req_valid  (read_req_valid),
        .read_req_pr     (read_req_pr),
        .read_req_ready  (read_req_ready),
        .read_resp_valid (read_resp_valid),
        .read_resp_data  (read_resp_data),
        .wb_valid        (wb_valid),
        .wb_pr           (wb_pr),
        .wb_data         (wb_data),
        .wb_ready        (wb_ready),
        .wb_bus_valid    (wb_bus_valid),
        .wb_bus_upper_pr (wb_bus_upper_pr),
        .forward_data    (forward_data)
    );

    // Galois LFSR on x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [31:0] take_bits(input int nbits);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            value = {value[30:0], lfsr[0]};
            lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return value;
    endfunction

    task automatic check_true(input bit ok, input string what);
        check_count++;
        assert (ok) else begin
            error_count++;
            $display("FAIL %0t: %s", $time, what);
        end
    endtask

    function automatic bit queues_empty();
        bit empty;
        empty = 1'b1;
        for (int rr = 0; rr < RR; rr++) begin
            empty &= (rd_pending[rr].size() == 0);
        end
        for (int w = 0; w < WR; w++) begin
            empty &= (wr_pend_pr[w].size() == 0);
        end
        return empty;
    endfunction

    function automatic bit goals_met(input int rd_goal, input int wr_goal);
        bit met;
        met = 1'b1;
        for (int rr = 0; rr < RR; rr++) begin
            met &= (rd_accepted[rr] >= rd_goal);
        end
        for (int w = 0; w < WR; w++) begin
            met &= (wr_accepted[w] >= wr_goal);
        end
        return met;
    endfunction

    // --------------------------------------------------
    // monitor sampling settled values at the falling edge
    // --------------------------------------------------

    task automatic observe_cycle();
        int         bank_hits [BANKS];
        int         w_hit;
        pr_t        pr;
        bank_mask_t committed;
        pr_t        commit_pr [BANKS];
        reg_data_t  commit_data [BANKS];
        committed = '0;
        for (int b = 0; b < BANKS; b++) begin
            bank_hits[b] = 0;
            if (fwd_due[b]) begin
                check_true(forward_data[b] === fwd_data[b],
                    $sformatf("bank %0d forward_data %h, expected %h",
                              b, forward_data[b], fwd_data[b]));
            end
        end
        // ready is high while the buffer has room
        for (int rr = 0; rr < RR; rr++) begin
            check_true(read_req_ready[rr] === (rd_pending[rr].size() < DEPTH),
                $sformatf("read_req_ready[%0d] is %b with %0d pending",
                          rr, read_req_ready[rr], rd_pending[rr].size()));
            if (!read_req_ready[rr]) begin
                saw_ready_low = 1'b1;
            end
        end
        for (int w = 0; w < WR; w++) begin
            check_true(wb_ready[w] === (wr_pend_pr[w].size() < DEPTH),
                $sformatf("wb_ready[%0d] is %b with %0d pending",
                          w, wb_ready[w], wr_pend_pr[w].size()));
        end
        // reads see the array before this cycle's writes
        for (int rr = 0; rr < RR; rr++) begin
            if (read_resp_valid[rr]) begin
                resp_count[rr]++;
                check_true(rd_pending[rr].size() != 0,
                    $sformatf("read response on requestor %0d with no pending read", rr));
                if (rd_pending[rr].size() != 0) begin
                    pr = rd_pending[rr].pop_front();
                    bank_hits[bank_t'(pr)]++;
                    check_true(read_resp_data[rr] === model_regs[pr],
                        $sformatf("requestor %0d read PR %0d got %h, expected %h",
                                  rr, pr, read_resp_data[rr], model_regs[pr]));
                end
            end
        end
        for (int b = 0; b < BANKS; b++) begin
            check_true(bank_hits[b] <= 2,
                $sformatf("bank %0d answered %0d reads in one cycle", b, bank_hits[b]));
        end
        // writeback bus must match the head of one writer
        for (int b = 0; b < BANKS; b++) begin
            if (wb_bus_valid[b]) begin
                wb_bus_count++;
                w_hit = -1;
                for (int w = 0; w < WR; w++) begin
                    if (w_hit < 0 && wr_pend_pr[w].size() != 0 &&
                        bank_t'(wr_pend_pr[w][0]) == b &&
                        upper_pr_t'(wr_pend_pr[w][0] >> BANK_W) == wb_bus_upper_pr[b]) begin
                        w_hit = w;
                    end
                end
                check_true(w_hit >= 0,
                    $sformatf("bank %0d writeback of upper PR %0d matches no pending write",
                              b, wb_bus_upper_pr[b]));
                if (w_hit >= 0) begin
                    committed[b]   = 1'b1;
                    commit_pr[b]   = wr_pend_pr[w_hit].pop_front();
                    commit_data[b] = wr_pend_data[w_hit].pop_front();
                end
            end
        end
        for (int rr = 0; rr < RR; rr++) begin
            if (read_req_valid[rr] && read_req_ready[rr]) begin
                rd_pending[rr].push_back(read_req_pr[rr]);
                rd_accepted[rr]++;
            end
        end
        for (int w = 0; w < WR; w++) begin
            if (wb_valid[w] && wb_ready[w]) begin
                wr_pend_pr[w].push_back(wb_pr[w]);
                wr_pend_data[w].push_back(wb_data[w]);
                wr_accepted[w]++;
            end
        end
        for (int b = 0; b < BANKS; b++) begin
            if (committed[b]) begin
                model_regs[commit_pr[b]] = commit_data[b];
                fwd_data[b] = commit_data[b];
            end
        end
        fwd_due = committed;
    endtask

    always @(negedge CLK) begin
        if (nRST) begin
            observe_cycle();
        end
    end

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------

    task automatic drive_idle();
        read_req_valid = '0;
        read_req_pr    = '0;
        wb_valid       = '0;
        wb_pr          = '0;
        wb_data        = '0;
    endtask

    // writer w only owns PRs with bit 2 equal to w
    task automatic drive_cycle(input int rd_goal, input int wr_goal, input bit init_mode,
                               input bit one_bank, input bank_t bank);
        logic [3:0] k;
        for (int rr = 0; rr < RR; rr++) begin
            read_req_valid[rr] = (rd_accepted[rr] < rd_goal) && (one_bank || take_bits(1));
            read_req_pr[rr]    = one_bank ? {upper_pr_t'(take_bits(3)), bank}
                                          : pr_t'(take_bits(5));
        end
        for (int w = 0; w < WR; w++) begin
            k           = init_mode ? 4'(wr_accepted[w]) : 4'(take_bits(4));
            wb_valid[w] = (wr_accepted[w] < wr_goal) && (init_mode || take_bits(1));
            wb_pr[w]    = {k[3:2], 1'(w), k[1:0]};
            wb_data[w]  = take_bits(32);
        end
    endtask

    task automatic run_traffic(input string phase, input int rd_goal, input int wr_goal,
                               input bit init_mode, input bit one_bank, input bank_t bank);
        int cycles;
        cycles = 0;
        while (!goals_met(rd_goal, wr_goal) && cycles < TIMEOUT) begin
            @(posedge CLK);
            #1;
            drive_cycle(rd_goal, wr_goal, init_mode, one_bank, bank);
            cycles++;
        end
        if (!goals_met(rd_goal, wr_goal)) begin
            $display("timeout: %s requests were not all accepted in %0d cycles", phase, TIMEOUT);
            timed_out = 1'b1;
        end
        @(posedge CLK);
        #1;
        drive_idle();
    endtask

    task automatic wait_drain(input string phase);
        int cycles;
        cycles = 0;
        while (!queues_empty() && cycles < TIMEOUT) begin
            @(posedge CLK);
            cycles++;
        end
        if (!queues_empty()) begin
            $display("timeout: %s left requests unanswered after %0d cycles", phase, TIMEOUT);
            timed_out = 1'b1;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (error_count == errors_before && !timed_out) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, error_count - errors_before);
        end
    endtask

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------

    initial begin
        int    cycles;
        int    errors_before;
        int    wr_total;
        bank_t hot_bank;
        lfsr          = SEED;
        timed_out     = 1'b0;
        saw_ready_low = 1'b0;
        fwd_due       = '0;
        wb_bus_count  = 0;
        check_count   = 0;
        error_count   = 0;
        drive_idle();

        cycles = 0;
        while (nRST !== 1'b1 && cycles < 10) begin
            @(posedge CLK);
            cycles++;
        end
        if (nRST !== 1'b1) begin
            $display("timeout: reset was never released");
            timed_out = 1'b1;
        end

        errors_before = error_count;
        @(negedge CLK);
        check_true(read_req_ready === '1 && wb_ready === '1, "ready low after reset");
        check_true(read_resp_valid === '0 && wb_bus_valid === '0, "valid high after reset");
        check_true(forward_data === '0, "forward_data not zero after reset");
        report_test("reset_values", errors_before);

        if (!timed_out) begin
            errors_before = error_count;
            run_traffic("init_writes", 0, INIT_WRITES, 1'b1, 1'b0, '0);
            wait_drain("init_writes");
            report_test("init_writes", errors_before);
        end

        if (!timed_out) begin
            errors_before = error_count;
            run_traffic("random_traffic", RAND_READS, INIT_WRITES + RAND_WRITES,
                        1'b0, 1'b0, '0);
            wait_drain("random_traffic");
            report_test("random_traffic", errors_before);
        end

        // all readers on one bank so the buffers fill
        if (!timed_out) begin
            errors_before = error_count;
            saw_ready_low = 1'b0;
            hot_bank      = bank_t'(take_bits(2));
            run_traffic("bank_conflict", RAND_READS + HOT_READS, 0, 1'b0, 1'b1, hot_bank);
            wait_drain("bank_conflict");
            check_true(saw_ready_low, "read_req_ready never dropped under bank conflict");
            report_test("bank_conflict", errors_before);
        end

        if (!timed_out) begin
            errors_before = error_count;
            for (int rr = 0; rr < RR; rr++) begin
                check_true(resp_count[rr] == rd_accepted[rr],
                    $sformatf("requestor %0d answered %0d of %0d reads",
                              rr, resp_count[rr], rd_accepted[rr]));
            end
            wr_total = 0;
            for (int w = 0; w < WR; w++) begin
                wr_total += wr_accepted[w];
            end
            check_true(wb_bus_count == wr_total,
                $sformatf("writeback bus carried %0d of %0d writes",
                          wb_bus_count, wr_total));
            report_test("final_counts", errors_before);
        end

        $display("checks run: %0d, errors: %0d", check_count, error_count);
        if (timed_out || error_count != 0) begin
            $display("TEST FAIL");
        end else begin
            $display("TEST PASS");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+logic
logic/prf_pkg.sv
logic/req_buffer.sv
logic/rr_arbiter.sv
logic/rr_dual_arbiter.sv
logic/prf_bank_ram.sv
logic/prf_read_path.sv
logic/prf_write_path.sv
logic/prf.sv
sim/prf_clk_gen.sv
sim/prf_tb.sv
